// ==== source/lc4_ss_config.svh ====
`ifndef LC4_SS_CONFIG_SVH
`define LC4_SS_CONFIG_SVH

// datapath and instruction width
`define LC4_WORD_W 16

// register file geometry
`define LC4_REG_SEL_W 3
`define LC4_NUM_REGS 8

// first fetch address after reset
`define LC4_RESET_PC 16'h8200

// opcode field insn[15:12] for the supported groups
`define LC4_OP_CONST 4'b1001
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101

`endif

// ==== source/lc4_ss_pkg.sv ====
`default_nettype none

`include "lc4_ss_config.svh"

package lc4_ss_pkg;

    typedef logic [`LC4_WORD_W-1:0] word_t;
    typedef logic [`LC4_REG_SEL_W-1:0] reg_sel_t;

    // operation carried down a lane, anything unsupported becomes ALU_NOP
    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_CONST,
        ALU_ADD,
        ALU_SUB,
        ALU_ADDI,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // register usage of one instruction
    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     rd_we;
        alu_op_t  alu_op;
    } decoded_t;

    // one instruction leaving decode
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    insn;
        decoded_t dec;
    } slot_t;

    // stage result, also the commit record at W
    typedef struct packed {
        logic       valid;
        word_t      pc;
        word_t      insn;
        logic       rd_we;
        reg_sel_t   rd;
        word_t      data;
        logic [2:0] nzp;
    } result_t;

endpackage

`default_nettype wire

// ==== source/lc4_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc4_ss_config.svh"

module lc4_decoder (
    input  wire  lc4_ss_pkg::word_t    i_insn,
    output       lc4_ss_pkg::decoded_t o_dec
);
    import lc4_ss_pkg::*;

    alu_op_t op;

    // pick the operation from opcode and sub-opcode
    always_comb begin
        op = ALU_NOP;
        case (i_insn[15:12])
            `LC4_OP_CONST: op = ALU_CONST;
            `LC4_OP_ARITH: begin
                if (i_insn[5]) begin
                    op = ALU_ADDI;
                end else if (i_insn[4:3] == 2'b00) begin
                    op = ALU_ADD;
                end else if (i_insn[4:3] == 2'b10) begin
                    op = ALU_SUB;
                end
            end
            `LC4_OP_LOGIC: begin
                // the immediate AND form and NOT are not supported
                if (!i_insn[5]) begin
                    case (i_insn[4:3])
                        2'b00: op = ALU_AND;
                        2'b10: op = ALU_OR;
                        2'b11: op = ALU_XOR;
                        default: op = ALU_NOP;
                    endcase
                end
            end
            default: op = ALU_NOP;
        endcase
    end

    // enables follow the operation, selects are zero when unused
    always_comb begin
        o_dec.alu_op = op;
        o_dec.rd_we  = (op != ALU_NOP);
        o_dec.rs_re  = (op != ALU_NOP) && (op != ALU_CONST);
        o_dec.rt_re  = o_dec.rs_re && (op != ALU_ADDI);
        o_dec.rd     = o_dec.rd_we ? i_insn[11:9] : '0;
        o_dec.rs     = o_dec.rs_re ? i_insn[8:6] : '0;
        o_dec.rt     = o_dec.rt_re ? i_insn[2:0] : '0;
    end

endmodule

`default_nettype wire

// ==== source/lc4_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc4_ss_config.svh"

module lc4_issue (
    input  wire  gwe,
    input  wire  i_reset,
    input  wire  lc4_ss_pkg::word_t i_insn_a,
    input  wire  lc4_ss_pkg::word_t i_insn_b,
    output       lc4_ss_pkg::word_t o_cur_pc,
    output       lc4_ss_pkg::slot_t o_slot_a,
    output       lc4_ss_pkg::slot_t o_slot_b
);
    import lc4_ss_pkg::*;

    word_t    pc;
    word_t    pc_next;
    decoded_t dec_a;
    decoded_t dec_b;
    logic     b_needs_a;

    // both fetched words are decoded ahead of the pair register
    lc4_decoder u_dec_a (
        .i_insn (i_insn_a),
        .o_dec  (dec_a)
    );

    lc4_decoder u_dec_b (
        .i_insn (i_insn_b),
        .o_dec  (dec_b)
    );

    // B reads the register A is about to write
    assign b_needs_a = dec_a.rd_we &&
                       ((dec_b.rs_re && (dec_b.rs == dec_a.rd)) ||
                        (dec_b.rt_re && (dec_b.rt == dec_a.rd)));

    // a split pair refetches B as the next A
    assign pc_next = b_needs_a ? pc + word_t'(1) : pc + word_t'(2);

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc <= `LC4_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign o_cur_pc = pc;

    // decode stage pair register
    always_ff @(posedge gwe) begin
        o_slot_a.pc   <= pc;
        o_slot_a.insn <= i_insn_a;
        o_slot_a.dec  <= dec_a;
        o_slot_b.pc   <= pc + word_t'(1);
        o_slot_b.insn <= i_insn_b;
        o_slot_b.dec  <= dec_b;
        if (i_reset) begin
            o_slot_a.valid <= 1'b0;
            o_slot_b.valid <= 1'b0;
        end else begin
            o_slot_a.valid <= 1'b1;
            // deferred B becomes a bubble in this pair
            o_slot_b.valid <= !b_needs_a;
        end
    end

endmodule

`default_nettype wire

// ==== source/lc4_exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_exec_lane (
    input  wire  gwe,
    input  wire  i_reset,
    input  wire  lc4_ss_pkg::slot_t   i_slot,
    input  wire  lc4_ss_pkg::word_t   i_rs_data,
    input  wire  lc4_ss_pkg::word_t   i_rt_data,
    input  wire  lc4_ss_pkg::result_t i_m_a,
    input  wire  lc4_ss_pkg::result_t i_m_b,
    input  wire  lc4_ss_pkg::result_t i_w_a,
    input  wire  lc4_ss_pkg::result_t i_w_b,
    output       lc4_ss_pkg::result_t o_m,
    output       lc4_ss_pkg::result_t o_w
);
    import lc4_ss_pkg::*;

    slot_t   x_slot;
    word_t   x_rs_data;
    word_t   x_rt_data;
    word_t   rs_val;
    word_t   rt_val;
    word_t   alu_out;
    result_t x_res;

    // a source forwards only a real register write to the same register
    function automatic logic hits(result_t src, reg_sel_t sel);
        return src.valid && src.rd_we && (src.rd == sel);
    endfunction

    // youngest producer first: M before W, B before A
    function automatic word_t bypass(reg_sel_t sel, word_t rf_val,
                                     result_t ma, result_t mb,
                                     result_t wa, result_t wb);
        if (hits(mb, sel)) begin
            return mb.data;
        end else if (hits(ma, sel)) begin
            return ma.data;
        end else if (hits(wb, sel)) begin
            return wb.data;
        end else if (hits(wa, sel)) begin
            return wa.data;
        end
        return rf_val;
    endfunction

    function automatic logic [2:0] nzp_of(word_t value);
        if (value[15]) begin
            return 3'b100;
        end else if (value == '0) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    // X stage register
    always_ff @(posedge gwe) begin
        x_slot    <= i_slot;
        x_rs_data <= i_rs_data;
        x_rt_data <= i_rt_data;
        if (i_reset) begin
            x_slot.valid <= 1'b0;
        end
    end

    assign rs_val = bypass(x_slot.dec.rs, x_rs_data, i_m_a, i_m_b, i_w_a, i_w_b);
    assign rt_val = bypass(x_slot.dec.rt, x_rt_data, i_m_a, i_m_b, i_w_a, i_w_b);

    always_comb begin
        case (x_slot.dec.alu_op)
            ALU_CONST: alu_out = {{7{x_slot.insn[8]}}, x_slot.insn[8:0]};
            ALU_ADD:   alu_out = rs_val + rt_val;
            ALU_SUB:   alu_out = rs_val - rt_val;
            ALU_ADDI:  alu_out = rs_val + {{11{x_slot.insn[4]}}, x_slot.insn[4:0]};
            ALU_AND:   alu_out = rs_val & rt_val;
            ALU_OR:    alu_out = rs_val | rt_val;
            ALU_XOR:   alu_out = rs_val ^ rt_val;
            default:   alu_out = '0;
        endcase
    end

    always_comb begin
        x_res.valid = x_slot.valid;
        x_res.pc    = x_slot.pc;
        x_res.insn  = x_slot.insn;
        x_res.rd_we = x_slot.dec.rd_we;
        x_res.rd    = x_slot.dec.rd;
        x_res.data  = alu_out;
        x_res.nzp   = nzp_of(alu_out);
    end

    // M and W just carry the finished result
    always_ff @(posedge gwe) begin
        o_m <= x_res;
        o_w <= o_m;
        if (i_reset) begin
            o_m.valid <= 1'b0;
            o_w.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/lc4_regfile_ss.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc4_ss_config.svh"

module lc4_regfile_ss (
    input  wire  gwe,
    input  wire  i_reset,
    input  wire  lc4_ss_pkg::reg_sel_t i_rs_a,
    input  wire  lc4_ss_pkg::reg_sel_t i_rt_a,
    input  wire  lc4_ss_pkg::reg_sel_t i_rs_b,
    input  wire  lc4_ss_pkg::reg_sel_t i_rt_b,
    input  wire  lc4_ss_pkg::result_t  i_wr_a,
    input  wire  lc4_ss_pkg::result_t  i_wr_b,
    output       lc4_ss_pkg::word_t    o_rs_data_a,
    output       lc4_ss_pkg::word_t    o_rt_data_a,
    output       lc4_ss_pkg::word_t    o_rs_data_b,
    output       lc4_ss_pkg::word_t    o_rt_data_b
);
    import lc4_ss_pkg::*;

    word_t regs [`LC4_NUM_REGS];

    // pending write wins over the stored value, B over A
    function automatic word_t read_port(reg_sel_t sel, word_t stored,
                                        result_t wa, result_t wb);
        if (wb.valid && wb.rd_we && (wb.rd == sel)) begin
            return wb.data;
        end else if (wa.valid && wa.rd_we && (wa.rd == sel)) begin
            return wa.data;
        end
        return stored;
    endfunction

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_wr_a.valid && i_wr_a.rd_we) begin
                regs[i_wr_a.rd] <= i_wr_a.data;
            end
            // issued second so B overrides A on the same register
            if (i_wr_b.valid && i_wr_b.rd_we) begin
                regs[i_wr_b.rd] <= i_wr_b.data;
            end
        end
    end

    assign o_rs_data_a = read_port(i_rs_a, regs[i_rs_a], i_wr_a, i_wr_b);
    assign o_rt_data_a = read_port(i_rt_a, regs[i_rt_a], i_wr_a, i_wr_b);
    assign o_rs_data_b = read_port(i_rs_b, regs[i_rs_b], i_wr_a, i_wr_b);
    assign o_rt_data_b = read_port(i_rt_b, regs[i_rt_b], i_wr_a, i_wr_b);

endmodule

`default_nettype wire

// ==== source/lc4_ss_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_ss_core (
    input  wire  gwe,
    input  wire  i_reset,
    input  wire  lc4_ss_pkg::word_t   i_insn_a,
    input  wire  lc4_ss_pkg::word_t   i_insn_b,
    output       lc4_ss_pkg::word_t   o_cur_pc,
    output       lc4_ss_pkg::result_t o_commit_a,
    output       lc4_ss_pkg::result_t o_commit_b
);
    import lc4_ss_pkg::*;

    slot_t   slot_a;
    slot_t   slot_b;
    word_t   rs_data_a;
    word_t   rt_data_a;
    word_t   rs_data_b;
    word_t   rt_data_b;
    result_t m_a;
    result_t m_b;
    result_t w_a;
    result_t w_b;

    lc4_issue u_issue (
        .gwe      (gwe),
        .i_reset  (i_reset),
        .i_insn_a (i_insn_a),
        .i_insn_b (i_insn_b),
        .o_cur_pc (o_cur_pc),
        .o_slot_a (slot_a),
        .o_slot_b (slot_b)
    );

    // decode reads, W writes back
    lc4_regfile_ss u_regfile (
        .gwe         (gwe),
        .i_reset     (i_reset),
        .i_rs_a      (slot_a.dec.rs),
        .i_rt_a      (slot_a.dec.rt),
        .i_rs_b      (slot_b.dec.rs),
        .i_rt_b      (slot_b.dec.rt),
        .i_wr_a      (w_a),
        .i_wr_b      (w_b),
        .o_rs_data_a (rs_data_a),
        .o_rt_data_a (rt_data_a),
        .o_rs_data_b (rs_data_b),
        .o_rt_data_b (rt_data_b)
    );

    // both lanes see all four later-stage results for bypass
    lc4_exec_lane u_lane_a (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_slot    (slot_a),
        .i_rs_data (rs_data_a),
        .i_rt_data (rt_data_a),
        .i_m_a     (m_a),
        .i_m_b     (m_b),
        .i_w_a     (w_a),
        .i_w_b     (w_b),
        .o_m       (m_a),
        .o_w       (w_a)
    );

    lc4_exec_lane u_lane_b (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_slot    (slot_b),
        .i_rs_data (rs_data_b),
        .i_rt_data (rt_data_b),
        .i_m_a     (m_a),
        .i_m_b     (m_b),
        .i_w_a     (w_a),
        .i_w_b     (w_b),
        .o_m       (m_b),
        .o_w       (w_b)
    );

    assign o_commit_a = w_a;
    assign o_commit_b = w_b;

endmodule

`default_nettype wire

// ==== bench/tb_lc4_ss.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lc4_ss_config.svh"

module tb_lc4_ss;
    import lc4_ss_pkg::*;

    localparam int PAT_WORDS = 256;

    logic    gwe = 1'b0;
    logic    i_reset;
    word_t   insn_a;
    word_t   insn_b;
    word_t   cur_pc;
    result_t commit_a;
    result_t commit_b;

    // program length, program words, record count, then 5 words per record
    word_t pattern [PAT_WORDS];
    int    prog_len;
    int    rec_count;
    int    rec_base;
    int    next_rec = 0;
    int    errors = 0;
    int    cycles = 0;
    int    live_edges = 0;

    lc4_ss_core DUT (
        .gwe        (gwe),
        .i_reset    (i_reset),
        .i_insn_a   (insn_a),
        .i_insn_b   (insn_b),
        .o_cur_pc   (cur_pc),
        .o_commit_a (commit_a),
        .o_commit_b (commit_b)
    );

    always #20 gwe = ~gwe;

    function automatic word_t pattern_at(int pos);
        logic [7:0] p;
        p = 8'(pos);
        return pattern[p];
    endfunction

    function automatic logic in_program(word_t pc);
        return (pc >= `LC4_RESET_PC) && (int'(pc - `LC4_RESET_PC) < prog_len);
    endfunction

    // instruction memory, anything outside the program reads as NOP
    function automatic word_t fetch_word(word_t pc);
        if (in_program(pc)) begin
            return pattern_at(int'(pc - `LC4_RESET_PC) + 1);
        end
        return '0;
    endfunction

    always_comb begin
        insn_a = fetch_word(cur_pc);
        insn_b = fetch_word(cur_pc + 16'd1);
    end

    always @(posedge gwe) begin
        cycles <= cycles + 1;
        if (!i_reset) begin
            live_edges <= live_edges + 1;
        end
    end

    // compare one commit with the next record in program order
    task automatic check_commit(input result_t c, input string port);
        int    base;
        word_t exp_pc;
        word_t exp_we;
        word_t exp_rd;
        word_t exp_data;
        word_t exp_nzp;
        word_t exp_insn;
        if (c.valid && in_program(c.pc)) begin
            assert (next_rec < rec_count) else begin
                errors++;
                $display("ERROR at %0t ns: extra commit on port %s, pc %h", $time, port, c.pc);
            end
            if (next_rec < rec_count) begin
                base     = rec_base + 5 * next_rec;
                exp_pc   = pattern_at(base);
                exp_we   = pattern_at(base + 1);
                exp_rd   = pattern_at(base + 2);
                exp_data = pattern_at(base + 3);
                exp_nzp  = pattern_at(base + 4);
                exp_insn = fetch_word(exp_pc);
                assert ((c.pc == exp_pc) && (c.rd_we == exp_we[0])) else begin
                    errors++;
                    $display("ERROR at %0t ns: port %s pc %h we %b, expected pc %h we %b",
                             $time, port, c.pc, c.rd_we, exp_pc, exp_we[0]);
                end
                // the commit carries the word fetched at its pc
                assert (c.insn == exp_insn) else begin
                    errors++;
                    $display("ERROR at %0t ns: port %s pc %h insn %h, expected %h",
                             $time, port, c.pc, c.insn, exp_insn);
                end
                // rd, data and nzp only matter for a write
                if (exp_we[0]) begin
                    assert ((c.rd == exp_rd[2:0]) && (c.data == exp_data) &&
                            (c.nzp == exp_nzp[2:0])) else begin
                        errors++;
                        $display("ERROR at %0t ns: pc %h r%0d=%h nzp %b, expected r%0d=%h nzp %b",
                                 $time, c.pc, c.rd, c.data, c.nzp,
                                 exp_rd[2:0], exp_data, exp_nzp[2:0]);
                    end
                end
                next_rec++;
            end
        end
    endtask

    // outputs are settled mid cycle
    always @(negedge gwe) begin
        if (live_edges == 0) begin
            assert (cur_pc == `LC4_RESET_PC) else begin
                errors++;
                $display("ERROR at %0t ns: pc %h in reset, expected %h",
                         $time, cur_pc, `LC4_RESET_PC);
            end
        end
        // first pair needs four edges to reach W
        if (live_edges < 4) begin
            assert (!commit_a.valid && !commit_b.valid) else begin
                errors++;
                $display("ERROR at %0t ns: commit before the first pair reached W", $time);
            end
        end
        if (commit_b.valid && in_program(commit_b.pc)) begin
            assert (commit_a.valid && (commit_a.pc + 16'd1 == commit_b.pc)) else begin
                errors++;
                $display("ERROR at %0t ns: port B pc %h not preceded by port A pc %h",
                         $time, commit_b.pc, commit_a.pc);
            end
        end
        check_commit(commit_a, "A");
        check_commit(commit_b, "B");
    end

    initial begin
        int setup_faults;
        int cycle_limit;
        setup_faults = 0;
        i_reset = 1'b1;
        // unloaded words hold a value tied to their address
        for (int i = 0; i < PAT_WORDS; i++) begin
            pattern[i] = word_t'(i) ^ 16'ha5a5;
        end
        $readmemh("bench/lc4_ss_patterns.mem", pattern);
        prog_len    = int'(pattern_at(0));
        rec_count   = int'(pattern_at(prog_len + 1));
        rec_base    = prog_len + 2;
        cycle_limit = prog_len * 2 + 20;
        assert (rec_count > 0) else begin
            setup_faults++;
            $display("the pattern file holds no expected commit records");
        end
        repeat (3) @(posedge gwe);
        i_reset <= 1'b0;
        while ((next_rec < rec_count) && (cycles < cycle_limit)) begin
            @(posedge gwe);
        end
        assert (next_rec >= rec_count) else begin
            setup_faults++;
            $display("timeout after %0d cycles, %0d of %0d expected commits never arrived",
                     cycles, rec_count - next_rec, rec_count);
        end
        // trailing cycles catch stray commits
        repeat (4) @(posedge gwe);
        $display("commits checked %0d of %0d, errors %0d",
                 next_rec, rec_count, errors + setup_faults);
        if (errors + setup_faults == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/lc4_ss_patterns.mem ====
// first word is the program length, then the instruction words from pc 8200
// then the record count, one record per line: pc rd_we rd data nzp
0017
9205 95fd 1642 1852 5adc 16c5 5d02 5e56 // const, add, sub, xor, split pair at 8205
127f 9400 9464 1881 0000 1a57 5a08 1d69 // addi, same rd in one pair, nop, not
5105 1f80 1fc7 9300 1447 5690 192f      // bypass chains, two more splits
0017
8200 1 1 0005 1
8201 1 2 fffd 4
8202 1 3 0002 1
8203 1 4 0008 1
8204 1 5 000a 1
8205 1 3 000c 1
8206 1 6 0008 1
8207 1 7 000d 1
8208 1 1 0004 1
8209 1 2 0000 2
820a 1 2 0064 1
820b 1 4 0068 1
820c 0 0 0000 0
820d 1 5 fff7 4
820e 0 0 0000 0
820f 1 6 0000 2
8210 1 0 0060 1
8211 1 7 0060 1
8212 1 7 00c0 1
8213 1 1 ff00 4
8214 1 2 ffc0 4
8215 1 3 ffe0 4
8216 1 4 0077 1

// ==== vlog.f ====
+incdir+source
source/lc4_ss_pkg.sv
source/lc4_decoder.sv
source/lc4_issue.sv
source/lc4_exec_lane.sv
source/lc4_regfile_ss.sv
source/lc4_ss_core.sv
bench/tb_lc4_ss.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_lc4_ss
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
